/* sim.f */
src/freelist_pkg.sv
src/freelist_dealloc_decode.sv
src/freelist_free_vector.sv
src/freelist_alloc_stage.sv
src/freelist_top.sv
tests/freelist_tb.sv

/* tests/freelist_tb.sv */
/*
 * Free list manager testbench
 * Drives the allocation and deallocation ports, tracks the held entries
 * in a model and checks grants, back pressure and the deallocation count.
 */

`timescale 1ns/1ns
`default_nettype none

module freelist_tb;

  import freelist_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int RESET_CYCLES = 2;
  localparam int RANDOM_CYCLES = 400;
  // Rough length of all directed phases, well above what they need
  localparam int DIRECTED_CYCLES = 200;
  localparam int MARGIN_CYCLES = 100;
  localparam int DRAIN_LIMIT = 4 * NUM_ENTRIES;
  localparam int unsigned SEED = 32'h9e08b615;

  logic                           clk;
  logic                           rst_n;
  dealloc_bus_t                   dealloc;
  logic                           alloc_ready;
  alloc_out_t                     alloc;
  logic [DEALLOC_COUNT_WIDTH-1:0] dealloc_count;

  // Model of the entries the user currently holds
  entry_vec_t   held;
  // Strobes seen at the last rising edge, for the count check
  dealloc_bus_t prev_dealloc;
  // Port value and stall flag from the last rising edge
  alloc_out_t   last_alloc;
  logic         hold_pending;
  // High while grants must come out lowest entry first
  logic         order_check;
  int           grants;
  int           errors;
  int unsigned  seed_value;
  int unsigned  first_draw;

  freelist_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .dealloc       (dealloc),
    .alloc_ready   (alloc_ready),
    .alloc         (alloc),
    .dealloc_count (dealloc_count)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Number of ports that strobed in a given cycle
  function automatic logic [DEALLOC_COUNT_WIDTH-1:0] expected_count(dealloc_bus_t d);
    logic [DEALLOC_COUNT_WIDTH-1:0] n;
    n = '0;
    for (int i = 0; i < NUM_DEALLOC_PORTS; i++) begin
      if (d[i].valid) begin
        n = n + 1'b1;
      end
    end
    return n;
  endfunction

  // Lowest entry that the model does not hold
  function automatic entry_id_t lowest_free(entry_vec_t h);
    entry_id_t id;
    id = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (!h[i]) begin
        id = entry_id_t'(i);
      end
    end
    return id;
  endfunction

  // Comparison process, all outputs are registered so the edge sees settled values
  always @(posedge clk) begin
    if (rst_n) begin
      assert (dealloc_count == expected_count(prev_dealloc)) else begin
        errors++;
        $display("Error: dealloc_count expected %h actual %h",
                 expected_count(prev_dealloc), dealloc_count);
      end
      // A stalled offer must not move
      if (hold_pending) begin
        assert (alloc == last_alloc) else begin
          errors++;
          $display("Error: alloc expected %h actual %h", last_alloc, alloc);
        end
      end
      if (alloc.valid && alloc_ready) begin
        assert (!held[alloc.id]) else begin
          errors++;
          $display("Error: alloc.id %h was granted while the model holds it", alloc.id);
        end
        if (order_check) begin
          assert (alloc.id == lowest_free(held)) else begin
            errors++;
            $display("Error: alloc.id expected %h actual %h", lowest_free(held), alloc.id);
          end
        end
        held[alloc.id] = 1'b1;
        grants++;
      end
      // Returned entries leave the model in the cycle of their strobe
      for (int p = 0; p < NUM_DEALLOC_PORTS; p++) begin
        if (dealloc[p].valid) begin
          held[dealloc[p].id] = 1'b0;
        end
      end
      prev_dealloc = dealloc;
      hold_pending = alloc.valid && !alloc_ready;
      last_alloc = alloc;
    end
  end

  // Pops every entry with ready high and expects them lowest first
  task automatic drain_in_order();
    int waited;
    waited = 0;
    @(negedge clk);
    dealloc = '0;
    grants = 0;
    order_check = 1'b1;
    alloc_ready = 1'b1;
    while (grants < NUM_ENTRIES && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
      // The next entry is loaded in the cycle of each pop, so no gap appears
      if (grants > 0 && grants < NUM_ENTRIES) begin
        assert (alloc.valid) else begin
          errors++;
          $display("Error: alloc.valid expected 1 actual 0 between grants of the drain");
        end
      end
    end
    assert (grants == NUM_ENTRIES) else begin
      errors++;
      $display("Error: grants expected %h actual %h", NUM_ENTRIES, grants);
    end
    assert (!alloc.valid) else begin
      errors++;
      $display("Error: alloc.valid expected 0 actual 1 after the drain");
    end
    order_check = 1'b0;
    alloc_ready = 1'b0;
  endtask

  // Pops whatever is left until the port goes idle, in any order
  task automatic drain_all();
    int waited;
    waited = 0;
    @(negedge clk);
    dealloc = '0;
    alloc_ready = 1'b1;
    repeat (2) @(negedge clk);
    while (alloc.valid && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    assert (!alloc.valid) else begin
      errors++;
      $display("Error: the allocation port kept offering entries after the drain limit");
    end
    assert (held == '1) else begin
      errors++;
      $display("Error: held expected %h actual %h", entry_vec_t'('1), held);
    end
    alloc_ready = 1'b0;
  endtask

  // Both ports return pairs of entries, lowest pair first
  task automatic return_all_ascending();
    for (int i = 0; i < NUM_ENTRIES; i += NUM_DEALLOC_PORTS) begin
      @(negedge clk);
      alloc_ready = 1'b0;
      for (int p = 0; p < NUM_DEALLOC_PORTS; p++) begin
        dealloc[p].valid = 1'b1;
        dealloc[p].id = entry_id_t'(i + p);
      end
    end
    @(negedge clk);
    dealloc = '0;
  endtask

  // With every entry held, a lone return reaches the port two cycles later
  task automatic single_returns(int reps);
    entry_id_t k;
    int port;
    for (int r = 0; r < reps; r++) begin
      k = entry_id_t'($urandom % NUM_ENTRIES);
      port = $urandom % NUM_DEALLOC_PORTS;
      @(negedge clk);
      alloc_ready = 1'b0;
      dealloc = '0;
      dealloc[port].valid = 1'b1;
      dealloc[port].id = k;
      @(negedge clk);
      dealloc = '0;
      assert (!alloc.valid) else begin
        errors++;
        $display("Error: alloc.valid expected 0 actual 1 one cycle after the return");
      end
      @(negedge clk);
      assert (alloc.valid && alloc.id == k) else begin
        errors++;
        $display("Error: alloc expected %h actual %h", {1'b1, k}, alloc);
      end
      alloc_ready = 1'b1;
      @(negedge clk);
      alloc_ready = 1'b0;
    end
  endtask

  // Two entries come back, then each offer waits a random stall before its pop
  task automatic back_pressure();
    entry_id_t a;
    int stall;
    a = entry_id_t'($urandom % NUM_ENTRIES);
    @(negedge clk);
    alloc_ready = 1'b0;
    dealloc[0].valid = 1'b1;
    dealloc[0].id = a;
    dealloc[1].valid = 1'b1;
    dealloc[1].id = a + entry_id_t'(1 + $urandom % (NUM_ENTRIES - 1));
    @(negedge clk);
    dealloc = '0;
    for (int r = 0; r < 2; r++) begin
      stall = 2 + $urandom % 5;
      repeat (stall) @(negedge clk);
      alloc_ready = 1'b1;
      @(negedge clk);
      alloc_ready = 1'b0;
    end
  endtask

  // Random ready and random returns of held entries on both ports
  task automatic random_traffic(int cycles);
    int candidates[$];
    int pick;
    entry_vec_t picked;
    for (int c = 0; c < cycles; c++) begin
      @(negedge clk);
      alloc_ready = ($urandom % 2) == 1;
      dealloc = '0;
      picked = '0;
      for (int p = 0; p < NUM_DEALLOC_PORTS; p++) begin
        candidates.delete();
        for (int i = 0; i < NUM_ENTRIES; i++) begin
          if (held[i] && !picked[i]) begin
            candidates.push_back(i);
          end
        end
        if (candidates.size() > 0 && ($urandom % 2) == 1) begin
          pick = candidates[$urandom % candidates.size()];
          picked[pick] = 1'b1;
          dealloc[p].valid = 1'b1;
          dealloc[p].id = entry_id_t'(pick);
        end
      end
    end
    @(negedge clk);
    dealloc = '0;
  endtask

  initial begin
    seed_value = SEED;
    first_draw = $urandom(seed_value);
    rst_n = 1'b0;
    alloc_ready = 1'b1;
    dealloc = '0;
    held = '0;
    prev_dealloc = '0;
    last_alloc = '0;
    hold_pending = 1'b0;
    order_check = 1'b0;
    grants = 0;
    errors = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    // Fresh pool hands out 0 to 15 in order
    drain_in_order();
    single_returns(6);
    repeat (3) back_pressure();
    random_traffic(RANDOM_CYCLES);
    drain_all();
    return_all_ascending();
    drain_in_order();
    @(negedge clk);
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the directed and random phase lengths
  initial begin
    #((DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d ns",
             (DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* src/freelist_top.sv */
/*
 * Free list manager
 * Pool of 16 entries with one valid/ready allocation port, two
 * deallocation ports and a registered count of returned entries.
 */

`timescale 1ns/1ns
`default_nettype none

module freelist_top (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  freelist_pkg::dealloc_bus_t                  dealloc,
  input  logic                                        alloc_ready,
  output freelist_pkg::alloc_out_t                    alloc,
  output logic [freelist_pkg::DEALLOC_COUNT_WIDTH-1:0] dealloc_count
);

  import freelist_pkg::*;

  // Entries returned this cycle, one bit per valid port
  entry_vec_t free_set;

  // Lowest free entry of the unstaged vector
  alloc_out_t cand;

  // High when the stage accepts cand this cycle
  logic take;

  // Strobes become a set mask and a delayed count
  freelist_dealloc_decode u_dealloc_decode (
    .clk           (clk),
    .rst_n         (rst_n),
    .dealloc       (dealloc),
    .free_set      (free_set),
    .dealloc_count (dealloc_count)
  );

  // Unstaged free entries and the priority pick
  freelist_free_vector u_free_vector (
    .clk      (clk),
    .rst_n    (rst_n),
    .free_set (free_set),
    .take     (take),
    .cand     (cand)
  );

  // Staging register in front of the allocation port
  // It feeds take back so the vector drops the entry it just staged
  freelist_alloc_stage u_alloc_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .cand        (cand),
    .alloc_ready (alloc_ready),
    .take        (take),
    .alloc       (alloc)
  );

endmodule

`default_nettype wire

/* src/freelist_alloc_stage.sv */
/*
 * Free list allocation stage
 * One deep forward register that stages a free entry ID and offers it
 * on the valid/ready allocation port.
 */

`timescale 1ns/1ns
`default_nettype none

module freelist_alloc_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  freelist_pkg::alloc_out_t cand,
  input  logic                     alloc_ready,
  output logic                     take,
  output freelist_pkg::alloc_out_t alloc
);

  import freelist_pkg::*;

  // Stage occupancy
  logic valid_q;

  // Staged entry ID, only meaningful while valid_q is high
  entry_id_t id_q;

  // A handshake on the allocation port in this cycle
  logic pop;

  assign pop = valid_q && alloc_ready;

  // The stage has room when it is empty or being emptied this cycle
  // The candidate is loaded in that same cycle, so back to back grants work
  assign take = cand.valid && (!valid_q || alloc_ready);

  // Occupancy follows the loads and the pops
  // A pop with nothing to load leaves the stage empty
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (take) begin
      valid_q <= 1'b1;
    end else if (pop) begin
      valid_q <= 1'b0;
    end
  end

  // The ID only changes on a load
  // Under back pressure take stays low and the ID is held
  always_ff @(posedge clk) begin
    if (take) begin
      id_q <= cand.id;
    end
  end

  assign alloc.valid = valid_q;
  assign alloc.id    = id_q;

  // A staged entry waits unchanged until the handshake completes
  a_alloc_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (alloc.valid && !alloc_ready) |=> $stable(alloc)
  ) else $error("Allocation output changed under back pressure");

endmodule

`default_nettype wire

/* src/freelist_free_vector.sv */
/*
 * Free list vector
 * Holds the free entries that are not staged for allocation and picks
 * the lowest numbered one as the candidate for the allocation stage.
 */

`timescale 1ns/1ns
`default_nettype none

module freelist_free_vector (
  input  logic                     clk,
  input  logic                     rst_n,
  input  freelist_pkg::entry_vec_t free_set,
  input  logic                     take,
  output freelist_pkg::alloc_out_t cand
);

  import freelist_pkg::*;

  // Unstaged free entries, every entry starts out free
  entry_vec_t free_q;
  entry_vec_t free_d;

  // Lowest set bit of free_q as a one hot mask
  entry_vec_t lowest_oh;

  // Bit to drop from the vector when the stage takes the candidate
  entry_vec_t clear_mask;

  // Binary index of the lowest set bit
  entry_id_t lowest_id;

  // Two's complement isolates the lowest set bit in one step
  assign lowest_oh = free_q & (~free_q + entry_vec_t'(1));

  // Encode the one hot mask to binary
  // At most one bit is set, so an OR of the indices is enough
  always_comb begin
    lowest_id = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (lowest_oh[i]) begin
        lowest_id = lowest_id | ENTRY_ID_WIDTH'(i);
      end
    end
  end

  // The candidate comes straight from the register
  assign cand.valid = |free_q;
  assign cand.id    = lowest_id;

  // The vector itself knows which bit the stage took
  assign clear_mask = take ? lowest_oh : '0;

  // Returned entries are never free or staged, so set and clear never collide
  assign free_d = (free_q | free_set) & ~clear_mask;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      free_q <= '1;
    end else begin
      free_q <= free_d;
    end
  end

  // An entry that is already free must not be returned again
  a_no_double_free: assert property (
    @(posedge clk) disable iff (!rst_n)
    (free_set & free_q) == '0
  ) else $error("Entry returned while already in the free vector");

  // The stage only takes a candidate that exists
  a_take_needs_cand: assert property (
    @(posedge clk) disable iff (!rst_n)
    take |-> cand.valid
  ) else $error("Stage took an entry from an empty free vector");

endmodule

`default_nettype wire

/* src/freelist_dealloc_decode.sv */
/*
 * Free list deallocation decoder
 * Turns the deallocation strobes into a set mask for the free vector
 * and a registered count of the entries returned in the last cycle.
 */

`timescale 1ns/1ns
`default_nettype none

module freelist_dealloc_decode (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  freelist_pkg::dealloc_bus_t                  dealloc,
  output freelist_pkg::entry_vec_t                    free_set,
  output logic [freelist_pkg::DEALLOC_COUNT_WIDTH-1:0] dealloc_count
);

  import freelist_pkg::*;

  // Number of valid ports in the current cycle
  logic [DEALLOC_COUNT_WIDTH-1:0] count_d;

  // Registered copy of count_d, one cycle behind the strobes
  logic [DEALLOC_COUNT_WIDTH-1:0] count_q;

  // Each valid port contributes one hot bit at its entry ID
  // The ports never name the same entry, so the OR never merges two returns
  always_comb begin
    free_set = '0;
    count_d  = '0;
    for (int i = 0; i < NUM_DEALLOC_PORTS; i++) begin
      if (dealloc[i].valid) begin
        free_set = free_set | (entry_vec_t'(1) << dealloc[i].id);
        count_d  = count_d + DEALLOC_COUNT_WIDTH'(1);
      end
    end
  end

  // The count lags the strobes by one cycle
  // This matches the cycle in which the returned entries land in the free vector
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else begin
      count_q <= count_d;
    end
  end

  assign dealloc_count = count_q;

  // Two ports returning the same entry in one cycle would count it twice
  // while only one bit reaches the free vector
  for (genvar i = 0; i < NUM_DEALLOC_PORTS; i++) begin : gen_port_a
    for (genvar j = i + 1; j < NUM_DEALLOC_PORTS; j++) begin : gen_port_b
      a_no_same_entry: assert property (
        @(posedge clk) disable iff (!rst_n)
        (dealloc[i].valid && dealloc[j].valid) |-> (dealloc[i].id != dealloc[j].id)
      ) else $error("Deallocation ports %0d and %0d return the same entry", i, j);
    end
  end

endmodule

`default_nettype wire

/* src/freelist_pkg.sv */
/*
 * Free list package
 * Pool constants and the packed types shared by the free list blocks,
 * for a pool of 16 entries with two deallocation ports.
 */

`default_nettype none

package freelist_pkg;

  // Number of entries managed by the free list
  localparam int NUM_ENTRIES = 16;

  // Number of ports that can each return one entry per cycle
  localparam int NUM_DEALLOC_PORTS = 2;

  // Bits needed to name one entry of the pool
  localparam int ENTRY_ID_WIDTH = $clog2(NUM_ENTRIES);

  // Bits needed to count from zero up to NUM_DEALLOC_PORTS returns
  localparam int DEALLOC_COUNT_WIDTH = $clog2(NUM_DEALLOC_PORTS + 1);

  // One entry ID
  typedef logic [ENTRY_ID_WIDTH-1:0] entry_id_t;

  // One bit per entry, bit i stands for entry i
  // It is used for the free vector and for the set and clear masks
  typedef logic [NUM_ENTRIES-1:0] entry_vec_t;

  // A single deallocation strobe with the entry it returns
  typedef struct packed {
    logic      valid;
    entry_id_t id;
  } dealloc_req_t;

  // All deallocation ports side by side, port 0 in the low bits
  typedef dealloc_req_t [NUM_DEALLOC_PORTS-1:0] dealloc_bus_t;

  // Allocation output and free vector candidate share this layout
  // The id field only carries meaning while valid is high
  typedef struct packed {
    logic      valid;
    entry_id_t id;
  } alloc_out_t;

endpackage

`default_nettype wire
